// File: common/coherence_consts.svh
// *******************************************************************
// coherence controller constants
// core count, bus width and two-word block layout shared by the
// memory controller blocks
// *******************************************************************
`ifndef COHERENCE_CONSTS_SVH
`define COHERENCE_CONSTS_SVH

// cache port pairs (one icache, one dcache per core)
`define NUM_CORES 2

// data and byte address width
`define WORD_W 32

// selects word 0 or 1 of a block
`define BLOCK_WORD_BIT 2

`endif

// File: common/coherence_pkg.sv
// *******************************************************************
// coherence package
// word, core index and mask types, RAM state code, arbiter request
// kinds and the bus phases of the memory controller
// *******************************************************************
`default_nettype none

`include "coherence_consts.svh"

package coherence_pkg;

	typedef logic [`WORD_W-1:0] word_t;	// data word or byte address

	typedef logic [$clog2(`NUM_CORES)-1:0] core_idx_t;	// 1 bit for 2 cores

	typedef logic [`NUM_CORES-1:0] core_mask_t;	// one bit per core

	// RAM state code, only ACCESS completes a word
	typedef enum logic [1:0] {
		FREE,
		BUSY,
		ACCESS,
		ERROR
	} ramstate_t;

	// winning request, latched by the arbiter
	typedef enum logic [1:0] {
		REQ_NONE,
		REQ_IFETCH,
		REQ_WRITEBACK,
		REQ_COHERENT
	} req_kind_t;

	// one bus transaction in flight at a time
	typedef enum logic [3:0] {
		IDLE,
		IFETCH,	// single instruction word
		WB0,	// dirty block word 0 to RAM
		WB1,
		SNOOP,	// servicer looks up the block
		FILL0,	// requester filled from RAM
		FILL1,
		XFER0,	// cache to cache, RAM updated too
		XFER1
	} bus_phase_t;

endpackage

`default_nettype wire

// File: memory_control/bus_arbiter.sv
// *******************************************************************
// bus arbiter
// picks the core and request kind for the next bus transaction:
// writeback, then coherent access, then instruction fetch
// *******************************************************************
`default_nettype none

`include "coherence_consts.svh"

module bus_arbiter
	import coherence_pkg::*;
(
	input  logic       CLK,
	input  logic       nRST,
	input  logic       grant,
	input  core_mask_t iren,
	input  core_mask_t dren,
	input  core_mask_t dwen,
	input  core_mask_t cctrans,
	output core_idx_t  req,
	output req_kind_t  kind
);

	core_mask_t coh_req;	// data side wants a snoop
	logic       fetch_tie;	// both icaches at once
	core_idx_t  win_req;
	req_kind_t  win_kind;
	core_idx_t  rr_q;	// core served first on the next fetch tie

	assign coh_req   = cctrans | dren;	// read miss always snoops
	assign fetch_tie = &iren;

	// lower core wins within a kind, ~mask[0] is the lowest set core of two
	always_comb
	begin
		win_req  = '0;
		win_kind = REQ_NONE;
		if (|dwen)
		begin
			win_kind = REQ_WRITEBACK;
			win_req  = core_idx_t'(~dwen[0]);
		end
		else if (|coh_req)
		begin
			win_kind = REQ_COHERENT;
			win_req  = core_idx_t'(~coh_req[0]);
		end
		else if (fetch_tie)
		begin
			win_kind = REQ_IFETCH;
			win_req  = rr_q;	// alternate on ties
		end
		else if (|iren)
		begin
			win_kind = REQ_IFETCH;
			win_req  = core_idx_t'(~iren[0]);
		end
	end

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			req  <= '0;
			kind <= REQ_NONE;
			rr_q <= '0;
		end
		else
		begin
			kind <= grant ? win_kind : REQ_NONE;	// pulse, sequencer launches on it
			if (grant && win_kind != REQ_NONE)
			begin
				req <= win_req;	// held for the whole transaction
			end
			if (grant && win_kind == REQ_IFETCH && fetch_tie)
			begin
				rr_q <= ~rr_q;	// other core goes first next time
			end
		end
	end

endmodule

`default_nettype wire

// File: memory_control/coherence_sequencer.sv
// *******************************************************************
// coherence sequencer
// bus phase FSM: instruction fetch, two-word writeback, snoop, fill
// from RAM and cache-to-cache transfer with RAM update
// *******************************************************************
`default_nettype none

`include "coherence_consts.svh"

module coherence_sequencer
	import coherence_pkg::*;
(
	input  logic       CLK,
	input  logic       nRST,
	input  req_kind_t  kind,
	input  core_idx_t  req,
	input  core_mask_t cctrans,
	input  core_mask_t ccwrite,
	input  ramstate_t  ramstate,
	output logic       grant,
	output bus_phase_t phase
);

	bus_phase_t next_phase;
	core_idx_t  serv;	// the other core
	logic       word_done;	// RAM finished the current word
	logic       snoop_first_q;	// first SNOOP cycle, servicer still settling

	assign serv      = ~req;
	assign word_done = (ramstate == ACCESS);

	// arbiter samples the request lines each idle cycle
	// without a launch pending, it latches REQ_NONE when nothing is there
	assign grant = (phase == IDLE) && (kind == REQ_NONE);

	always_comb
	begin
		next_phase = phase;
		case (phase)
			IDLE:
			begin
				case (kind)
					REQ_IFETCH:    next_phase = IFETCH;
					REQ_WRITEBACK: next_phase = WB0;
					REQ_COHERENT:  next_phase = SNOOP;
					default:       next_phase = IDLE;
				endcase
			end
			IFETCH:
			begin
				if (word_done)
				begin
					next_phase = IDLE;
				end
			end
			WB0:
			begin
				if (word_done)
				begin
					next_phase = WB1;
				end
			end
			WB1:
			begin
				// requester may chain straight into its snoop
				if (word_done)
				begin
					next_phase = cctrans[req] ? SNOOP : IDLE;
				end
			end
			SNOOP:
			begin
				// ccwrite of the servicer only valid after the stall cycle
				if (!snoop_first_q)
				begin
					next_phase = ccwrite[serv] ? XFER0 : FILL0;
				end
			end
			FILL0:
			begin
				if (word_done)
				begin
					next_phase = FILL1;
				end
			end
			FILL1:
			begin
				if (word_done)
				begin
					next_phase = IDLE;
				end
			end
			XFER0:
			begin
				if (word_done)
				begin
					next_phase = XFER1;
				end
			end
			XFER1:
			begin
				if (word_done)
				begin
					next_phase = IDLE;
				end
			end
			default:
			begin
				next_phase = IDLE;	// unused codes recover
			end
		endcase
	end

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			phase         <= IDLE;
			snoop_first_q <= 1'b0;
		end
		else
		begin
			phase         <= next_phase;
			snoop_first_q <= (next_phase == SNOOP) && (phase != SNOOP);	// any entry path
		end
	end

endmodule

`default_nettype wire

// File: memory_control/bus_steering.sv
// *******************************************************************
// bus steering
// combinational decode of the bus phase into RAM address, data and
// enables, and the per-core waits, loads and snoop signals
// *******************************************************************
`default_nettype none

`include "coherence_consts.svh"

module bus_steering
	import coherence_pkg::*;
(
	input  bus_phase_t phase,
	input  core_idx_t  req,
	input  ramstate_t  ramstate,
	input  word_t      ramload,
	input  word_t      iaddr [`NUM_CORES],
	input  word_t      daddr [`NUM_CORES],
	input  word_t      dstore [`NUM_CORES],
	input  core_mask_t ccwrite,
	output core_mask_t iwait,
	output core_mask_t dwait,
	output word_t      iload [`NUM_CORES],
	output word_t      dload [`NUM_CORES],
	output core_mask_t ccwait,
	output core_mask_t ccinv,
	output word_t      ccsnoopaddr [`NUM_CORES],
	output word_t      ramaddr,
	output word_t      ramstore,
	output logic       ramren,
	output logic       ramwen
);

	core_idx_t serv;	// servicer is always the other core
	logic      ram_ack;	// current word completes this cycle
	word_t     word_flip;	// toggles the word within a block

	assign serv      = ~req;
	assign ram_ack   = (ramstate == ACCESS);
	assign word_flip = word_t'(1) << `BLOCK_WORD_BIT;

	always_comb
	begin
		// idle bus, caches held off
		iwait       = '1;
		dwait       = '1;
		ccwait      = '0;
		ccinv       = '0;
		iload       = '{default: '0};
		dload       = '{default: '0};
		ccsnoopaddr = '{default: '0};
		ramaddr     = '0;
		ramstore    = '0;
		ramren      = 1'b0;
		ramwen      = 1'b0;

		case (phase)
			IFETCH:
			begin
				ramren     = 1'b1;
				ramaddr    = iaddr[req];
				iload[req] = ramload;	// only the requester sees it
				iwait[req] = !ram_ack;
			end
			WB0, WB1:
			begin
				ramwen     = 1'b1;
				ramaddr    = daddr[req];	// cache steps the word itself
				ramstore   = dstore[req];
				dwait[req] = !ram_ack;
			end
			SNOOP:
			begin
				// servicer stalled while it looks up the block
				ccwait[serv]      = 1'b1;
				ccsnoopaddr[serv] = daddr[req];
				ccinv[serv]       = ccwrite[req];	// requester will write
			end
			FILL0, FILL1:
			begin
				ramren     = 1'b1;
				ramaddr    = daddr[req];
				dload[req] = ramload;
				dwait[req] = !ram_ack;
			end
			XFER0, XFER1:
			begin
				// dirty block goes to RAM and to the requester together
				ramwen      = 1'b1;
				ramaddr     = daddr[serv];
				ramstore    = dstore[serv];
				dload[req]  = dstore[serv];
				dwait[req]  = !ram_ack;
				dwait[serv] = !ram_ack;	// servicer steps its word too
				ccinv[serv] = ccwrite[req];
				if (phase == XFER1)
				begin
					ccsnoopaddr[serv] = daddr[req] ^ word_flip;	// other word
				end
				else
				begin
					ccsnoopaddr[serv] = daddr[req];
				end
			end
			default:
			begin
				ramren = 1'b0;	// IDLE keeps the defaults
			end
		endcase
	end

endmodule

`default_nettype wire

// File: memory_control/memory_control.sv
// *******************************************************************
// memory controller for two cores
// shares one RAM port between the icache and dcache ports of both
// cores and runs the snoop exchange between the data caches
// *******************************************************************
`default_nettype none

`include "coherence_consts.svh"

module memory_control
	import coherence_pkg::*;
(
	input  logic       CLK,
	input  logic       nRST,
	// cache side
	input  core_mask_t iren,
	input  core_mask_t dren,
	input  core_mask_t dwen,
	input  core_mask_t cctrans,
	input  core_mask_t ccwrite,
	input  word_t      iaddr [`NUM_CORES],
	input  word_t      daddr [`NUM_CORES],
	input  word_t      dstore [`NUM_CORES],
	output core_mask_t iwait,
	output core_mask_t dwait,
	output core_mask_t ccwait,
	output core_mask_t ccinv,
	output word_t      iload [`NUM_CORES],
	output word_t      dload [`NUM_CORES],
	output word_t      ccsnoopaddr [`NUM_CORES],
	// RAM side
	output word_t      ramaddr,
	output word_t      ramstore,
	output logic       ramren,
	output logic       ramwen,
	input  word_t      ramload,
	input  ramstate_t  ramstate
);

	core_idx_t  req;	// latched requester
	req_kind_t  kind;	// launch code, valid one cycle
	logic       grant;	// arbiter latch strobe
	bus_phase_t phase;

	// winner selection, fetch round-robin
	bus_arbiter i_bus_arbiter (
		.CLK     (CLK),
		.nRST    (nRST),
		.grant   (grant),
		.iren    (iren),
		.dren    (dren),
		.dwen    (dwen),
		.cctrans (cctrans),
		.req     (req),
		.kind    (kind)
	);

	coherence_sequencer i_coherence_sequencer (
		.CLK      (CLK),
		.nRST     (nRST),
		.kind     (kind),
		.req      (req),
		.cctrans  (cctrans),
		.ccwrite  (ccwrite),
		.ramstate (ramstate),
		.grant    (grant),
		.phase    (phase)
	);

	// phase decode onto RAM and cache ports
	bus_steering i_bus_steering (
		.phase       (phase),
		.req         (req),
		.ramstate    (ramstate),
		.ramload     (ramload),
		.iaddr       (iaddr),
		.daddr       (daddr),
		.dstore      (dstore),
		.ccwrite     (ccwrite),
		.iwait       (iwait),
		.dwait       (dwait),
		.iload       (iload),
		.dload       (dload),
		.ccwait      (ccwait),
		.ccinv       (ccinv),
		.ccsnoopaddr (ccsnoopaddr),
		.ramaddr     (ramaddr),
		.ramstore    (ramstore),
		.ramren      (ramren),
		.ramwen      (ramwen)
	);

endmodule

`default_nettype wire

// File: tests/memory_control_assert.sv
// **********************************************************************
// memory controller protocol assertions
// RAM enable exclusivity, wait drops only on ACCESS, one snoop at a time
// **********************************************************************
`default_nettype none

`include "coherence_consts.svh"

module memory_control_assert
	import coherence_pkg::*;
(
	input wire logic       CLK,
	input wire logic       nRST,
	input wire core_mask_t iwait,
	input wire core_mask_t dwait,
	input wire core_mask_t ccwait,
	input wire logic       ramren,
	input wire logic       ramwen,
	input wire ramstate_t  ramstate
);

	int fails = 0;	// failed assertions so far

	// read and write never share a cycle
	a_ram_excl: assert property (@(posedge CLK) disable iff (!nRST) !(ramren && ramwen))
		else
		begin
			$error("ramren and ramwen high together");
			fails++;
		end

	a_one_ifetch: assert property (@(posedge CLK) disable iff (!nRST) iwait != '0)
		else
		begin
			$error("iwait low on both cores");
			fails++;
		end

	// a word only completes on ACCESS
	a_wait_access: assert property (@(posedge CLK) disable iff (!nRST)
		((iwait != '1) || (dwait != '1)) |-> (ramstate == ACCESS))
		else
		begin
			$error("wait dropped without ACCESS");
			fails++;
		end

	a_one_snoop: assert property (@(posedge CLK) disable iff (!nRST) !(&ccwait))
		else
		begin
			$error("ccwait high on both cores");
			fails++;
		end

endmodule

bind memory_control memory_control_assert i_memory_control_assert (.*);

`default_nettype wire

// File: tests/memory_control_tb.sv
// **********************************************************************
// memory controller testbench
// table of fetch, writeback and snoop transactions against a RAM model
// with random BUSY latency, cache models hold requests until wait drops
// **********************************************************************
`default_nettype none

`include "coherence_consts.svh"

module memory_control_tb
	import coherence_pkg::*;
;
	localparam int NROWS = 14;
	localparam int PERIOD = 8;
	localparam int WATCHDOG = NROWS * 2 * 4 * PERIOD * 4 + 4000;	// 4 words max, margin
	localparam int FETCH = 0, FETCH2 = 1, WB = 2, WBCOH = 3, COH = 4;
	localparam word_t FLIP = word_t'(1) << `BLOCK_WORD_BIT;

	typedef struct packed {
		logic [2:0] kind;
		logic       core;	// requester
		word_t      addr;
		word_t      addr2;	// core 1 fetch or chained snoop block
		word_t      st0, st1;	// store words, writer or dirty servicer
		logic       dirty;	// servicer ccwrite
		logic       rw;	// requester ccwrite
		word_t      exp0, exp1;
	} row_t;

	logic CLK = 0, nRST = 0;
	core_mask_t iren, dren, dwen, cctrans, ccwrite, iwait, dwait, ccwait, ccinv;
	word_t iaddr [`NUM_CORES], daddr [`NUM_CORES], dstore [`NUM_CORES];
	word_t iload [`NUM_CORES], dload [`NUM_CORES], ccsnoopaddr [`NUM_CORES];
	word_t ramaddr, ramstore, ramload;
	logic ramren, ramwen;
	ramstate_t ramstate = FREE;
	word_t mem [256];
	row_t tbl [NROWS];
	logic [31:0] lfsr = 32'hafc3_4e63;
	int errors = 0, checks = 0, cnt = 0, last_first = -1;
	logic fresh = 1;

	memory_control i_memory_control (.*);

	always #(PERIOD/2) CLK = ~CLK;

	// initial RAM content, every address bit matters
	function automatic word_t fill_word(input word_t a);
		return {a[15:0] ^ 16'h9e37, ~a[15:0]} ^ {a[31:16], 16'h0};
	endfunction

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);	// galois step
		return b;
	endfunction

	task automatic check_eq(input word_t got, input word_t exp, input string msg);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	assign ramload = mem[ramaddr[9:2]];

	// RAM model, 0 to 3 BUSY cycles per word then ACCESS
	always @(negedge CLK)
	begin
		if (!nRST || !(ramren || ramwen))
		begin
			ramstate <= FREE;
			fresh = 1;
		end
		else
		begin
			if (fresh)
				cnt = {lfsr_bit(), lfsr_bit()};
			fresh = (cnt == 0);
			ramstate <= (cnt == 0) ? ACCESS : BUSY;
			cnt = cnt - 1;
		end
	end

	always @(posedge CLK)
		if (ramwen && ramstate == ACCESS)
			mem[ramaddr[9:2]] <= ramstore;

	task automatic fetch_words(input row_t r);
		logic [1:0] done;
		int first;
		done = r.kind == FETCH2 ? 2'b00 : (r.core ? 2'b01 : 2'b10);
		first = -1;
		@(negedge CLK);
		iaddr[0] = r.addr;
		iaddr[1] = r.kind == FETCH2 ? r.addr2 : r.addr;
		iren = ~done;
		while (done != 2'b11)
		begin
			@(posedge CLK);
			for (int c = 0; c < 2; c++)
				if (!iwait[c])
				begin
					check_eq(iload[c], (r.kind == FETCH2 && c) ? r.exp1 : r.exp0, "iload");
					check_eq(iload[1-c], '0, "iload of idle core");	// requester only
					done[c] = 1'b1;
					if (first < 0)
						first = c;
				end
			@(negedge CLK);
			iren = iren & ~done;
		end
		if (r.kind == FETCH2)
		begin
			if (last_first >= 0)
				check_eq(first, 1 - last_first, "fetch tie alternation");
			last_first = first;
		end
	endtask

	// snoop and two block words, daddr[c] already set to the block
	task automatic coherent_read(input row_t r, input word_t a);
		int c, s;
		c = r.core;
		s = 1 - c;
		do @(posedge CLK); while (!ccwait[s]);
		check_eq(ccsnoopaddr[s], a, "snoop address");
		check_eq(ccinv, r.rw ? word_t'(1) << s : '0, "ccinv in snoop");
		@(negedge CLK);
		ccwrite[s] = r.dirty;	// servicer lookup result
		daddr[s] = a;
		dstore[s] = r.st0;
		for (int w = 0; w < 2; w++)
		begin
			do @(posedge CLK); while (dwait[c]);
			check_eq(dload[c], w ? r.exp1 : r.exp0, "dload");
			if (r.dirty)
			begin
				// word 1 request address with its word bit inverted
				check_eq(ccsnoopaddr[s], w ? (a & ~FLIP) : a, "xfer snoop address");
				check_eq(ccinv, r.rw ? word_t'(1) << s : '0, "ccinv in xfer");
			end
			@(negedge CLK);
			daddr[c] = a | FLIP;	// next word
			daddr[s] = a | FLIP;
			dstore[s] = r.st1;
		end
		cctrans = '0;
		ccwrite = '0;
	endtask

	task automatic writeback_block(input row_t r);
		int c;
		c = r.core;
		@(negedge CLK);
		dwen[c] = 1'b1;
		cctrans[c] = (r.kind == WBCOH);	// chain into the snoop
		daddr[c] = r.addr;
		dstore[c] = r.st0;
		for (int w = 0; w < 2; w++)
		begin
			do @(posedge CLK); while (dwait[c]);
			@(negedge CLK);
			daddr[c] = r.addr | FLIP;
			dstore[c] = r.st1;
		end
		dwen = '0;
		if (r.kind == WBCOH)
		begin
			daddr[c] = r.addr2;
			ccwrite[c] = r.rw;
			coherent_read(r, r.addr2);
		end
	endtask

	function automatic row_t entry(input int k, input logic c, input word_t a, input word_t a2,
		input word_t s0, input word_t s1, input logic d, input logic rw, input word_t e0,
		input word_t e1);
		return '{k, c, a, a2, s0, s1, d, rw, e0, e1};
	endfunction

	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(i << 2);
		iren = '0;
		dren = '0;
		dwen = '0;
		cctrans = '0;
		ccwrite = '0;
		iaddr = '{default: '0};
		daddr = '{default: '0};
		dstore = '{default: '0};
		tbl[0]  = entry(FETCH, 0, 'h040, 0, 0, 0, 0, 0, fill_word('h040), 0);
		tbl[1]  = entry(FETCH, 1, 'h044, 0, 0, 0, 0, 0, fill_word('h044), 0);
		tbl[2]  = entry(FETCH2, 0, 'h080, 'h0c0, 0, 0, 0, 0, fill_word('h080), fill_word('h0c0));
		tbl[3]  = entry(FETCH2, 0, 'h100, 'h104, 0, 0, 0, 0, fill_word('h100), fill_word('h104));
		tbl[4]  = entry(WB, 0, 'h200, 0, 'hdeadbeef, 'hcafef00d, 0, 0, 0, 0);
		tbl[5]  = entry(FETCH, 1, 'h200, 0, 0, 0, 0, 0, 'hdeadbeef, 0);
		tbl[6]  = entry(FETCH, 0, 'h204, 0, 0, 0, 0, 0, 'hcafef00d, 0);
		tbl[7]  = entry(COH, 1, 'h300, 0, 0, 0, 0, 1, fill_word('h300), fill_word('h304));
		tbl[8]  = entry(COH, 0, 'h310, 0, 'h11112222, 'h33334444, 1, 1, 'h11112222, 'h33334444);
		tbl[9]  = entry(FETCH, 1, 'h314, 0, 0, 0, 0, 0, 'h33334444, 0);
		tbl[10] = entry(COH, 1, 'h320, 0, 'h5555aaaa, 'h6666bbbb, 1, 0, 'h5555aaaa, 'h6666bbbb);
		tbl[11] = entry(WBCOH, 1, 'h280, 'h340, 'h0badc0de, 'h12345678, 0, 0,
			fill_word('h340), fill_word('h344));
		tbl[12] = entry(FETCH, 0, 'h284, 0, 0, 0, 0, 0, 'h12345678, 0);
		tbl[13] = entry(FETCH2, 0, 'h280, 'h184, 0, 0, 0, 0, 'h0badc0de, fill_word('h184));
		repeat (2) @(negedge CLK);
		nRST = 1;
		@(posedge CLK);
		check_eq(iwait, {`NUM_CORES{1'b1}}, "iwait after reset");
		check_eq(dwait, {`NUM_CORES{1'b1}}, "dwait after reset");
		check_eq({ramren, ramwen, ccwait, ccinv}, '0, "enables after reset");
		for (int i = 0; i < NROWS; i++)
			case (tbl[i].kind)
				FETCH, FETCH2: fetch_words(tbl[i]);
				WB, WBCOH: writeback_block(tbl[i]);
				default:
				begin
					@(negedge CLK);
					cctrans[tbl[i].core] = 1'b1;
					ccwrite[tbl[i].core] = tbl[i].rw;
					daddr[tbl[i].core] = tbl[i].addr;
					coherent_read(tbl[i], tbl[i].addr);
				end
			endcase
		check_eq(mem['h310 >> 2], 'h11112222, "ram after xfer word 0");
		check_eq(mem['h324 >> 2], 'h6666bbbb, "ram after xfer word 1");
		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			i_memory_control.i_memory_control_assert.fails);
		if (errors == 0 && i_memory_control.i_memory_control_assert.fails == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG);
		$display("timeout: the controller stopped completing transactions");
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/coherence_pkg.sv
memory_control/bus_arbiter.sv
memory_control/coherence_sequencer.sv
memory_control/bus_steering.sv
memory_control/memory_control.sv
tests/memory_control_assert.sv
tests/memory_control_tb.sv

// File: Bender.yml
package:
  name: memory_control

sources:
  - include_dirs:
      - common
    files:
      - common/coherence_pkg.sv
      - memory_control/bus_arbiter.sv
      - memory_control/coherence_sequencer.sv
      - memory_control/bus_steering.sv
      - memory_control/memory_control.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/memory_control_assert.sv
      - tests/memory_control_tb.sv
